// File: logic/hdmi_pkg.sv
package hdmi_pkg;

    // Data lanes, clock lane not counted
    localparam int num_channels = 3;

    // Reduced frame, 16x8 visible inside 24x12
    localparam logic [4:0] h_active = 5'd16;
    localparam logic [4:0] h_total = 5'd24;
    localparam logic [4:0] h_sync_start = 5'd18;
    localparam logic [4:0] h_sync_end = 5'd20;

    localparam logic [3:0] v_active = 4'd8;
    localparam logic [3:0] v_total = 4'd12;
    localparam logic [3:0] v_sync_start = 4'd9;
    localparam logic [3:0] v_sync_end = 4'd10;

    // Word aligned register offsets
    localparam logic [7:0] addr_ctrl = 8'h00;
    localparam logic [7:0] addr_color = 8'h04;

    // Bit positions in CTRL
    localparam int ctrl_enable_bit = 0;
    localparam int ctrl_pattern_bit = 1;

    // Blanking symbols, suffix is {vsync, hsync}
    localparam logic [9:0] ctrl_symbol_00 = 10'b1101010100;
    localparam logic [9:0] ctrl_symbol_01 = 10'b0010101011;
    localparam logic [9:0] ctrl_symbol_10 = 10'b0101010100;
    localparam logic [9:0] ctrl_symbol_11 = 10'b1010101011;

    // Written in send order, first bit on the left
    localparam logic [9:0] clock_lane_word = 10'b0000011111;

endpackage

// File: logic/video_timing.sv
module video_timing
(
    input logic clk_pixel,
    input logic reset,
    output logic [4:0] cx,
    output logic [3:0] cy,
    output logic hsync,
    output logic vsync,
    output logic draw
);

    logic [4:0] h_count;
    logic [3:0] v_count;

    always_ff @(posedge clk_pixel)
    begin
        if (reset)
        begin
            h_count <= '0;
            v_count <= '0;
        end
        else if (h_count == hdmi_pkg::h_total - 5'd1)
        begin
            h_count <= '0;
            v_count <= (v_count == hdmi_pkg::v_total - 4'd1) ? 4'd0 : v_count + 4'd1;
        end
        else
        begin
            h_count <= h_count + 5'd1;
        end
    end

    // Position leaves in step with the flags
    always_ff @(posedge clk_pixel)
    begin
        if (reset)
        begin
            cx <= '0;
            cy <= '0;
            hsync <= 1'b0;
            vsync <= 1'b0;
            draw <= 1'b0;
        end
        else
        begin
            cx <= h_count;
            cy <= v_count;
            hsync <= h_count >= hdmi_pkg::h_sync_start && h_count < hdmi_pkg::h_sync_end;
            vsync <= v_count >= hdmi_pkg::v_sync_start && v_count < hdmi_pkg::v_sync_end;
            draw <= h_count < hdmi_pkg::h_active && v_count < hdmi_pkg::v_active;
        end
    end

    assert property (@(posedge clk_pixel) disable iff (reset) cx < hdmi_pkg::h_total);

endmodule

// File: logic/apb_config.sv
module apb_config
(
    input logic clk_pixel,
    input logic reset,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [7:0] paddr,
    input logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    output logic enable,
    output logic pattern,
    output logic [23:0] color
);

    logic access;
    logic mapped;

    assign access = psel && penable;
    assign mapped = paddr == hdmi_pkg::addr_ctrl || paddr == hdmi_pkg::addr_color;

    // No wait states
    assign pready = 1'b1;
    assign pslverr = access && !mapped;

    always_ff @(posedge clk_pixel)
    begin
        if (reset)
        begin
            enable <= 1'b0;
            pattern <= 1'b0;
            color <= '0;
        end
        else if (access && pwrite)
        begin
            if (paddr == hdmi_pkg::addr_ctrl)
            begin
                enable <= pwdata[hdmi_pkg::ctrl_enable_bit];
                pattern <= pwdata[hdmi_pkg::ctrl_pattern_bit];
            end
            else if (paddr == hdmi_pkg::addr_color)
            begin
                color <= pwdata[23:0];
            end
        end
    end

    always_comb
    begin
        prdata = '0;
        if (access && !pwrite)
        begin
            case (paddr)
                hdmi_pkg::addr_ctrl:
                begin
                    prdata[hdmi_pkg::ctrl_enable_bit] = enable;
                    prdata[hdmi_pkg::ctrl_pattern_bit] = pattern;
                end
                hdmi_pkg::addr_color:
                begin
                    prdata[23:0] = color;
                end
                default:
                begin
                    prdata = '0;
                end
            endcase
        end
    end

    // Access phase only after a setup phase
    assert property (@(posedge clk_pixel) disable iff (reset)
        penable |-> psel && $past(psel && !penable));

endmodule

// File: logic/pixel_source.sv
module pixel_source
(
    input logic [4:0] cx,
    input logic [3:0] cy,
    input logic pattern,
    input logic [23:0] color,
    output logic [7:0] chan_data [hdmi_pkg::num_channels-1:0]
);

    // Lane order is blue, green, red
    always_comb
    begin
        if (pattern)
        begin
            chan_data[0] = 8'd128;
            chan_data[1] = 8'({cy, 5'b00000});
            chan_data[2] = 8'({cx, 4'b0000});
        end
        else
        begin
            chan_data[0] = color[7:0];
            chan_data[1] = color[15:8];
            chan_data[2] = color[23:16];
        end
    end

endmodule

// File: logic/tmds_channel.sv
module tmds_channel
(
    input logic clk_pixel,
    input logic reset,
    input logic [7:0] data,
    input logic [1:0] ctrl,
    input logic video_on,
    output logic [9:0] symbol
);

    logic [3:0] data_ones;
    logic use_xnor;
    logic [8:0] q_m;
    logic [3:0] q_m_ones;
    logic signed [5:0] balance;
    logic signed [5:0] disparity;
    logic signed [5:0] disparity_next;
    logic [9:0] data_symbol;
    logic [9:0] ctrl_symbol;

    always_comb
    begin
        data_ones = '0;
        for (int i = 0; i < 8; i++)
        begin
            data_ones = data_ones + 4'(data[i]);
        end
    end

    // Transition minimizing stage
    assign use_xnor = data_ones > 4'd4 || (data_ones == 4'd4 && !data[0]);

    always_comb
    begin
        q_m[0] = data[0];
        for (int i = 1; i < 8; i++)
        begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : q_m[i-1] ^ data[i];
        end
        q_m[8] = !use_xnor;
    end

    always_comb
    begin
        q_m_ones = '0;
        for (int i = 0; i < 8; i++)
        begin
            q_m_ones = q_m_ones + 4'(q_m[i]);
        end
    end

    // Ones minus zeros over q_m[7:0]
    assign balance = $signed({1'b0, q_m_ones, 1'b0}) - 6'sd8;

    // DC balancing stage
    always_comb
    begin
        if (disparity == 6'sd0 || q_m_ones == 4'd4)
        begin
            data_symbol = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            disparity_next = q_m[8] ? disparity + balance : disparity - balance;
        end
        else if ((disparity > 6'sd0 && q_m_ones > 4'd4) ||
                 (disparity < 6'sd0 && q_m_ones < 4'd4))
        begin
            data_symbol = {1'b1, q_m[8], ~q_m[7:0]};
            disparity_next = disparity + $signed({4'b0000, q_m[8], 1'b0}) - balance;
        end
        else
        begin
            data_symbol = {1'b0, q_m[8], q_m[7:0]};
            disparity_next = disparity - $signed({4'b0000, ~q_m[8], 1'b0}) + balance;
        end
    end

    always_comb
    begin
        case (ctrl)
            2'b00: ctrl_symbol = hdmi_pkg::ctrl_symbol_00;
            2'b01: ctrl_symbol = hdmi_pkg::ctrl_symbol_01;
            2'b10: ctrl_symbol = hdmi_pkg::ctrl_symbol_10;
            default: ctrl_symbol = hdmi_pkg::ctrl_symbol_11;
        endcase
    end

    always_ff @(posedge clk_pixel)
    begin
        if (reset)
        begin
            symbol <= hdmi_pkg::ctrl_symbol_00;
            disparity <= '0;
        end
        else if (!video_on)
        begin
            symbol <= ctrl_symbol;
            disparity <= '0;
        end
        else
        begin
            symbol <= data_symbol;
            disparity <= disparity_next;
        end
    end

    assert property (@(posedge clk_pixel) disable iff (reset)
        disparity <= 6'sd10 && disparity >= -6'sd10);

endmodule

// File: logic/serializer.sv
module serializer
(
    input logic clk_pixel,
    input logic clk_pixel_x5,
    input logic reset,
    input logic [9:0] tmds_internal [hdmi_pkg::num_channels-1:0],
    output logic [2:0] tmds,
    output logic tmds_clock
);

    logic [9:0] word_q [hdmi_pkg::num_channels-1:0];
    logic [3:0] position;

    always_ff @(posedge clk_pixel)
    begin
        word_q <= tmds_internal;
    end

    // DDR shift, bit 0 on the falling edge after the capture edge
    always_ff @(posedge clk_pixel_x5 or negedge clk_pixel_x5)
    begin
        if (reset)
        begin
            tmds <= '0;
            tmds_clock <= 1'b0;
            position <= '0;
        end
        else
        begin
            for (int i = 0; i < hdmi_pkg::num_channels; i++)
            begin
                tmds[i] <= word_q[i][position];
            end
            tmds_clock <= hdmi_pkg::clock_lane_word[4'd9 - position];
            position <= (position == 4'd9) ? 4'd0 : position + 4'd1;
        end
    end

endmodule

// File: logic/hdmi_tx.sv
module hdmi_tx
(
    input logic clk_pixel,
    input logic clk_pixel_x5,
    input logic reset,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [7:0] paddr,
    input logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    output logic [2:0] tmds,
    output logic tmds_clock
);

    logic [4:0] cx;
    logic [3:0] cy;
    logic hsync;
    logic vsync;
    logic draw;
    logic enable;
    logic pattern;
    logic [23:0] color;
    logic video_on;
    logic [7:0] chan_data [hdmi_pkg::num_channels-1:0];
    logic [9:0] symbol [hdmi_pkg::num_channels-1:0];

    video_timing i_video_timing (.clk_pixel(clk_pixel), .reset(reset), .cx(cx), .cy(cy),
        .hsync(hsync), .vsync(vsync), .draw(draw));

    apb_config i_apb_config (.clk_pixel(clk_pixel), .reset(reset), .psel(psel),
        .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr), .enable(enable),
        .pattern(pattern), .color(color));

    pixel_source i_pixel_source (.cx(cx), .cy(cy), .pattern(pattern), .color(color),
        .chan_data(chan_data));

    // Blanking whenever output is off
    assign video_on = draw && enable;

    // Syncs ride on the blue lane
    tmds_channel i_tmds_channel_0 (.clk_pixel(clk_pixel), .reset(reset),
        .data(chan_data[0]), .ctrl({vsync, hsync}), .video_on(video_on), .symbol(symbol[0]));

    tmds_channel i_tmds_channel_1 (.clk_pixel(clk_pixel), .reset(reset),
        .data(chan_data[1]), .ctrl(2'b00), .video_on(video_on), .symbol(symbol[1]));

    tmds_channel i_tmds_channel_2 (.clk_pixel(clk_pixel), .reset(reset),
        .data(chan_data[2]), .ctrl(2'b00), .video_on(video_on), .symbol(symbol[2]));

    serializer i_serializer (.clk_pixel(clk_pixel), .clk_pixel_x5(clk_pixel_x5),
        .reset(reset), .tmds_internal(symbol), .tmds(tmds), .tmds_clock(tmds_clock));

endmodule

// File: sim/hdmi_tx_tb.sv
module hdmi_tx_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [1:0] {mode_off, mode_solid, mode_pattern} mode_t;

    logic clk_pixel = 1'b0;
    logic clk_pixel_x5 = 1'b0;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    logic [7:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic [2:0] tmds;
    logic tmds_clock;

    // Last colour is replaced from the seed
    logic [31:0] ctrl_table [4] = '{32'h2, 32'h1, 32'h3, 32'h1};
    logic [23:0] color_table [4] = '{24'h00ff80, 24'h3ca50f, 24'h3ca50f, 24'h000000};
    mode_t mode_table [4] = '{mode_off, mode_solid, mode_pattern, mode_solid};

    int seed = 32'hb946;
    int cycles = 0;
    int frame_words = int'(hdmi_pkg::h_total) * int'(hdmi_pkg::v_total);
    logic [9:0] clock_hist;
    logic [29:0] lane_hist;
    logic [29:0] words [$];
    logic [9:0] sym [3];

    hdmi_tx i_hdmi_tx (.clk_pixel(clk_pixel), .clk_pixel_x5(clk_pixel_x5), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr), .tmds(tmds),
        .tmds_clock(tmds_clock));

    always #50 clk_pixel = ~clk_pixel;
    always #10 clk_pixel_x5 = ~clk_pixel_x5;

    // Sampled halfway between x5 edges
    always @(clk_pixel_x5)
    begin
        #5;
        clock_hist = {tmds_clock, clock_hist[9:1]};
        for (int i = 0; i < hdmi_pkg::num_channels; i++)
        begin
            lane_hist[10*i +: 10] = {tmds[i], lane_hist[10*i+1 +: 9]};
        end
        // Five low then five high on the clock lane closes a word
        if (clock_hist == 10'b1111100000)
        begin
            words.push_back(lane_hist);
        end
    end

    always @(posedge clk_pixel)
    begin
        cycles <= cycles + 1;
        if (cycles > $size(ctrl_table) * 2 * frame_words + 200)
        begin
            fail_run($sformatf("Timeout, run still going after %0d pixel cycles", cycles));
        end
    end

    task automatic fail_run(string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_flag(string name, logic got, logic expected);
        if (got !== expected)
            fail_run($sformatf("[FAIL] %s got %h expected %h", name, got, expected));
    endtask

    task automatic check_symbol(string name, logic [9:0] got, logic [9:0] expected);
        if (got !== expected)
            fail_run($sformatf("[FAIL] %s got %h expected %h", name, got, expected));
    endtask

    task automatic check_byte(string name, logic [7:0] got, logic [7:0] expected);
        if (got !== expected)
            fail_run($sformatf("[FAIL] %s got %h expected %h", name, got, expected));
    endtask

    task automatic check_word(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected)
            fail_run($sformatf("[FAIL] %s got %h expected %h", name, got, expected));
    endtask

    task automatic check_count(string name, logic [4:0] got, logic [4:0] expected);
        if (got !== expected)
            fail_run($sformatf("[FAIL] %s got %h expected %h", name, got, expected));
    endtask

    // Undo the inversion, then the XOR or XNOR chain
    function automatic logic [7:0] decode_tmds(logic [9:0] s);
        logic [7:0] d;
        logic [7:0] q;
        d = s[9] ? ~s[7:0] : s[7:0];
        q[0] = d[0];
        for (int i = 1; i < 8; i++)
        begin
            q[i] = s[8] ? d[i] ^ d[i-1] : ~(d[i] ^ d[i-1]);
        end
        return q;
    endfunction

    task automatic apb_transfer(logic write, logic [7:0] addr, logic [31:0] wdata,
        output logic [31:0] rdata, output logic err);
        @(posedge clk_pixel);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= write;
        paddr <= addr;
        pwdata <= wdata;
        @(posedge clk_pixel);
        penable <= 1'b1;
        @(negedge clk_pixel);
        // Zero wait states, so ready in every access phase
        check_flag("pready", pready, 1'b1);
        rdata = prdata;
        err = pslverr;
        @(posedge clk_pixel);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic next_word();
        logic [29:0] w;
        while (words.size() == 0)
        begin
            @(posedge clk_pixel_x5);
        end
        w = words.pop_front();
        for (int i = 0; i < 3; i++)
        begin
            sym[i] = w[10*i +: 10];
        end
    endtask

    task automatic check_frame(mode_t mode, logic [23:0] color);
        logic prev_vs;
        logic vs;
        logic hs;
        int x;
        int y;
        logic [4:0] data_words;
        logic [4:0] hsync_words;
        logic [4:0] data_lines;
        logic [4:0] vsync_starts;
        int disparity [3];
        logic [7:0] expected [3];
        // Align on the first word of the vsync line
        vs = 1'b1;
        do
        begin
            prev_vs = vs;
            next_word();
            vs = sym[0] inside {hdmi_pkg::ctrl_symbol_10, hdmi_pkg::ctrl_symbol_11};
        end
        while (!vs || prev_vs);
        data_lines = '0;
        vsync_starts = '0;
        prev_vs = 1'b0;
        for (int n = 0; n < frame_words; n++)
        begin
            if (n > 0)
                next_word();
            x = n % int'(hdmi_pkg::h_total);
            y = (int'(hdmi_pkg::v_sync_start) + n / int'(hdmi_pkg::h_total))
                % int'(hdmi_pkg::v_total);
            if (x == 0)
            begin
                data_words = '0;
                hsync_words = '0;
                disparity = '{0, 0, 0};
            end
            hs = x >= hdmi_pkg::h_sync_start && x < hdmi_pkg::h_sync_end;
            vs = y >= hdmi_pkg::v_sync_start && y < hdmi_pkg::v_sync_end;
            expected[0] = mode == mode_pattern ? 8'd128 : color[7:0];
            expected[1] = mode == mode_pattern ? 8'(y * 32) : color[15:8];
            expected[2] = mode == mode_pattern ? 8'(x * 16) : color[23:16];
            for (int i = 0; i < 3; i++)
            begin
                if (mode != mode_off && x < hdmi_pkg::h_active && y < hdmi_pkg::v_active)
                begin
                    check_byte($sformatf("tmds[%0d] data x %0d y %0d", i, x, y),
                        decode_tmds(sym[i]), expected[i]);
                    disparity[i] += 2 * $countones(sym[i]) - 10;
                    if (disparity[i] > 10 || disparity[i] < -10)
                        fail_run($sformatf("DC balance lost on tmds[%0d] in line %0d", i, y));
                end
                else
                begin
                    check_symbol($sformatf("tmds[%0d] control x %0d y %0d", i, x, y), sym[i],
                        i > 0 ? hdmi_pkg::ctrl_symbol_00 :
                        vs ? (hs ? hdmi_pkg::ctrl_symbol_11 : hdmi_pkg::ctrl_symbol_10) :
                        (hs ? hdmi_pkg::ctrl_symbol_01 : hdmi_pkg::ctrl_symbol_00));
                end
            end
            // Counts taken from the received lane 0 symbols
            if (!(sym[0] inside {hdmi_pkg::ctrl_symbol_00, hdmi_pkg::ctrl_symbol_01,
                hdmi_pkg::ctrl_symbol_10, hdmi_pkg::ctrl_symbol_11}))
                data_words++;
            if (sym[0] inside {hdmi_pkg::ctrl_symbol_01, hdmi_pkg::ctrl_symbol_11})
                hsync_words++;
            vs = sym[0] inside {hdmi_pkg::ctrl_symbol_10, hdmi_pkg::ctrl_symbol_11};
            if (vs && !prev_vs)
                vsync_starts++;
            prev_vs = vs;
            if (x == int'(hdmi_pkg::h_total) - 1)
            begin
                check_count("data words per line", data_words,
                    (mode != mode_off && y < hdmi_pkg::v_active) ? hdmi_pkg::h_active : 5'd0);
                check_count("hsync words per line", hsync_words,
                    hdmi_pkg::h_sync_end - hdmi_pkg::h_sync_start);
                if (data_words != 0)
                    data_lines++;
            end
        end
        check_count("data lines per frame", data_lines,
            mode == mode_off ? 5'd0 : 5'(hdmi_pkg::v_active));
        check_count("vsync starts per frame", vsync_starts, 5'd1);
    endtask

    initial
    begin
        logic [31:0] rdata;
        logic err;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        color_table[3] = 24'($random(seed));
        repeat (8) @(posedge clk_pixel);
        reset <= 1'b0;
        apb_transfer(1'b1, hdmi_pkg::addr_ctrl, 32'h3, rdata, err);
        apb_transfer(1'b0, hdmi_pkg::addr_ctrl, 32'h0, rdata, err);
        check_word("prdata CTRL", rdata, 32'h3);
        check_flag("pslverr CTRL", err, 1'b0);
        apb_transfer(1'b1, hdmi_pkg::addr_color, 32'h00c3b2a1, rdata, err);
        apb_transfer(1'b0, hdmi_pkg::addr_color, 32'h0, rdata, err);
        check_word("prdata COLOR", rdata, 32'h00c3b2a1);
        // Offset 8 is unmapped
        apb_transfer(1'b1, 8'h08, 32'hffffffff, rdata, err);
        check_flag("pslverr write 08", err, 1'b1);
        apb_transfer(1'b0, 8'h08, 32'h0, rdata, err);
        check_word("prdata 08", rdata, 32'h0);
        check_flag("pslverr read 08", err, 1'b1);
        for (int e = 0; e < $size(ctrl_table); e++)
        begin
            apb_transfer(1'b1, hdmi_pkg::addr_ctrl, ctrl_table[e], rdata, err);
            apb_transfer(1'b1, hdmi_pkg::addr_color, {8'h00, color_table[e]}, rdata, err);
            words.delete();
            check_frame(mode_table[e], color_table[e]);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// File: hdmi_tx.f
logic/hdmi_pkg.sv
logic/video_timing.sv
logic/apb_config.sv
logic/pixel_source.sv
logic/tmds_channel.sv
logic/serializer.sv
logic/hdmi_tx.sv
sim/hdmi_tx_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator and run; exit status follows the simulation result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module hdmi_tx_tb \
    -f hdmi_tx.f -o hdmi_tx_sim &&
./obj_dir/hdmi_tx_sim || exit 1
